//--- hw/mmr_pkg.sv
package mmr_pkg;

    // Data path widths
    localparam int REG_W = 8;               // Register address and data byte
    localparam int CH_W  = 3;               // Bank bit plus two channel bits
    localparam int OP_W  = 2;

    // Credits and FIFO slots
    localparam int DEFAULT_FIFO_DEPTH = 4;

    // Global register map, bank 0 unless noted
    localparam logic [REG_W-1:0] REG_TESTYM  = 8'h21;
    localparam logic [REG_W-1:0] REG_LFO     = 8'h22;
    localparam logic [REG_W-1:0] REG_CLKA1   = 8'h24;  // Timer A upper bits
    localparam logic [REG_W-1:0] REG_CLKA2   = 8'h25;  // Timer A lower bits
    localparam logic [REG_W-1:0] REG_CLKB    = 8'h26;
    localparam logic [REG_W-1:0] REG_TIMER   = 8'h27;
    localparam logic [REG_W-1:0] REG_KON     = 8'h28;
    localparam logic [REG_W-1:0] REG_PCM     = 8'h2A;  // Either bank
    localparam logic [REG_W-1:0] REG_PCM_EN  = 8'h2B;  // Either bank
    localparam logic [REG_W-1:0] REG_DACTEST = 8'h2C;  // Either bank
    localparam logic [REG_W-1:0] REG_CLK_N6  = 8'h2D;
    localparam logic [REG_W-1:0] REG_CLK_N3  = 8'h2E;
    localparam logic [REG_W-1:0] REG_CLK_N2  = 8'h2F;

    // Divide ratio of the synth clock enable
    typedef enum logic [1:0] {
        PRESC_6 = 2'd0,
        PRESC_3 = 2'd1,
        PRESC_2 = 2'd2
    } presc_t;

    // Channel or operator register group hit by a data write
    typedef enum logic [3:0] {
        UPD_NONE    = 4'd0,
        UPD_KEYON   = 4'd1,
        UPD_FNUMLO  = 4'd2,
        UPD_ALG     = 4'd3,
        UPD_PMS     = 4'd4,
        UPD_DT1     = 4'd5,
        UPD_TL      = 4'd6,
        UPD_KS_AR   = 4'd7,
        UPD_AMEN_DR = 4'd8,
        UPD_SR      = 4'd9,
        UPD_SL_RR   = 4'd10,
        UPD_SSGEG   = 4'd11
    } upd_kind_t;

endpackage

//--- hw/bus_decoder.sv
module bus_decoder #(
    parameter int FIFO_DEPTH = mmr_pkg::DEFAULT_FIFO_DEPTH
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [mmr_pkg::REG_W-1:0] din,
    input  logic                      write,
    input  logic [1:0]                addr,
    input  logic                      credit_return,
    output logic                      push,
    output logic [mmr_pkg::REG_W-1:0] push_reg,
    output logic [mmr_pkg::REG_W-1:0] push_data,
    output logic                      push_bank,
    output mmr_pkg::presc_t           presc,
    output logic                      busy
);
    import mmr_pkg::*;

    localparam int CW = $clog2(FIFO_DEPTH + 1);

    logic [REG_W-1:0] sel_reg;     // Last register-select byte
    logic             sel_bank;
    logic [CW-1:0]    credits;
    logic             accept;

    // A data write goes through only while a FIFO slot is still free
    assign accept = write && addr[0] && (credits != '0);
    assign busy   = (credits == '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            sel_reg  <= '0;
            sel_bank <= 1'b0;
            presc    <= PRESC_6;
        end else if (write && !addr[0]) begin
            sel_reg  <= din;
            sel_bank <= addr[1];
            // Selecting a prescaler register is enough, data not needed
            case (din)
                REG_CLK_N6: presc <= PRESC_6;
                REG_CLK_N3: presc <= PRESC_3;
                REG_CLK_N2: presc <= PRESC_2;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            push <= 1'b0;
        end else begin
            push <= accept;
        end
    end

    // Write contents follow the accept strobe
    always_ff @(posedge clk) begin
        if (accept) begin
            push_reg  <= sel_reg;
            push_data <= din;
            push_bank <= sel_bank;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            credits <= CW'(FIFO_DEPTH);
        end else begin
            case ({accept, credit_return})
                2'b10:   credits <= credits - CW'(1);
                2'b01:   credits <= credits + CW'(1);
                default: ;                            // Both or neither
            endcase
        end
    end

endmodule

//--- hw/write_fifo.sv
module write_fifo #(
    parameter int FIFO_DEPTH = mmr_pkg::DEFAULT_FIFO_DEPTH
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      push,
    input  logic [mmr_pkg::REG_W-1:0] push_reg,
    input  logic [mmr_pkg::REG_W-1:0] push_data,
    input  logic                      push_bank,
    input  logic                      pop,
    output logic                      not_empty,
    output logic [mmr_pkg::REG_W-1:0] head_reg,
    output logic [mmr_pkg::REG_W-1:0] head_data,
    output logic                      head_bank
);
    import mmr_pkg::*;

    localparam int PW = $clog2(FIFO_DEPTH);
    localparam int CW = $clog2(FIFO_DEPTH + 1);

    logic [REG_W-1:0] mem_reg  [FIFO_DEPTH];
    logic [REG_W-1:0] mem_data [FIFO_DEPTH];
    logic             mem_bank [FIFO_DEPTH];
    logic [PW-1:0]    wr_ptr;
    logic [PW-1:0]    rd_ptr;
    logic [CW-1:0]    count;

    // Pointer step with wrap for depths that are not a power of two
    function automatic logic [PW-1:0] next_ptr(input logic [PW-1:0] p);
        if (p == PW'(FIFO_DEPTH - 1)) begin
            return '0;
        end
        return p + PW'(1);
    endfunction

    assign not_empty = (count != '0);
    assign head_reg  = mem_reg[rd_ptr];
    assign head_data = mem_data[rd_ptr];
    assign head_bank = mem_bank[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            mem_reg[wr_ptr]  <= push_reg;
            mem_data[wr_ptr] <= push_data;
            mem_bank[wr_ptr] <= push_bank;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= next_ptr(wr_ptr);
            if (pop) rd_ptr <= next_ptr(rd_ptr);
            case ({push, pop})
                2'b10:   count <= count + CW'(1);
                2'b01:   count <= count - CW'(1);
                default: ;
            endcase
        end
    end

endmodule

//--- hw/reg_bank.sv
module reg_bank (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      clk_en,
    input  logic                      not_empty,
    input  logic [mmr_pkg::REG_W-1:0] head_reg,
    input  logic [mmr_pkg::REG_W-1:0] head_data,
    input  logic                      head_bank,
    output logic                      pop,
    // Timers
    output logic [9:0]                value_a,
    output logic [7:0]                value_b,
    output logic                      load_a,
    output logic                      load_b,
    output logic                      enable_irq_a,
    output logic                      enable_irq_b,
    output logic                      clr_flag_a,
    output logic                      clr_flag_b,
    // Test and LFO
    output logic                      fast_timers,
    output logic                      eg_stop,
    output logic                      pg_stop,
    output logic                      lfo_en,
    output logic [2:0]                lfo_freq,
    output logic                      csm,
    output logic                      effect,
    // PCM DAC
    output logic [8:0]                pcm,
    output logic                      pcm_en,
    output logic                      pcm_wr,
    // Channel and operator update event
    output logic                      upd_valid,
    output mmr_pkg::upd_kind_t        upd_kind,
    output logic [mmr_pkg::CH_W-1:0]  upd_ch,
    output logic [mmr_pkg::OP_W-1:0]  upd_op,
    output logic [mmr_pkg::REG_W-1:0] upd_data
);
    import mmr_pkg::*;

    // Register group from address and bank
    function automatic upd_kind_t decode_kind(input logic [REG_W-1:0] r, input logic bank);
        upd_kind_t k;
        if (r == REG_KON && !bank) begin
            return UPD_KEYON;
        end
        if (r[1:0] == 2'b11) begin
            return UPD_NONE;                 // No fourth channel per bank
        end
        casez (r)
            8'hA0, 8'hA1, 8'hA2: k = UPD_FNUMLO;
            8'hB0, 8'hB1, 8'hB2: k = UPD_ALG;
            8'hB4, 8'hB5, 8'hB6: k = UPD_PMS;
            8'h3?:               k = UPD_DT1;
            8'h4?:               k = UPD_TL;
            8'h5?:               k = UPD_KS_AR;
            8'h6?:               k = UPD_AMEN_DR;
            8'h7?:               k = UPD_SR;
            8'h8?:               k = UPD_SL_RR;
            8'h9?:               k = UPD_SSGEG;
            default:             k = UPD_NONE;
        endcase
        return k;
    endfunction

    // One write per synth clock enable
    assign pop = clk_en && not_empty;

    always_ff @(posedge clk) begin
        if (rst) begin
            value_a      <= '0;
            value_b      <= '0;
            load_a       <= 1'b0;
            load_b       <= 1'b0;
            enable_irq_a <= 1'b0;
            enable_irq_b <= 1'b0;
            clr_flag_a   <= 1'b0;
            clr_flag_b   <= 1'b0;
            fast_timers  <= 1'b0;
            eg_stop      <= 1'b0;
            pg_stop      <= 1'b0;
            lfo_en       <= 1'b0;
            lfo_freq     <= '0;
            csm          <= 1'b0;
            effect       <= 1'b0;
            pcm          <= '0;
            pcm_en       <= 1'b0;
            pcm_wr       <= 1'b0;
            upd_valid    <= 1'b0;
        end else begin
            upd_valid <= pop;
            if (clk_en) begin                // One-shot bits drop here
                pcm_wr     <= 1'b0;
                clr_flag_a <= 1'b0;
                clr_flag_b <= 1'b0;
            end
            if (pop) begin
                if (!head_bank) begin
                    case (head_reg)
                        REG_TESTYM: begin
                            eg_stop     <= head_data[5];
                            pg_stop     <= head_data[3];
                            fast_timers <= head_data[2];
                        end
                        REG_LFO:   {lfo_en, lfo_freq} <= head_data[3:0];
                        REG_CLKA1: value_a[9:2] <= head_data;
                        REG_CLKA2: value_a[1:0] <= head_data[1:0];
                        REG_CLKB:  value_b <= head_data;
                        REG_TIMER: begin
                            effect <= |head_data[7:6];
                            csm    <= (head_data[7:6] == 2'b10);
                            {clr_flag_b, clr_flag_a, enable_irq_b, enable_irq_a,
                             load_b, load_a} <= head_data[5:0];
                        end
                        default: ;
                    endcase
                end
                // DAC registers answer in both banks
                case (head_reg)
                    REG_PCM:     pcm <= {~head_data[7], head_data[6:0], 1'b1};
                    REG_PCM_EN:  pcm_en <= head_data[7];
                    REG_DACTEST: pcm[0] <= head_data[3];
                    default: ;
                endcase
                pcm_wr <= (head_reg == REG_PCM);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            upd_kind <= decode_kind(head_reg, head_bank);
            upd_ch   <= {head_bank, head_reg[1:0]};
            upd_op   <= head_reg[3:2];           // Slot order S1 S3 S2 S4
            upd_data <= head_data;
        end
    end

endmodule

//--- hw/cen_divider.sv
module cen_divider (
    input  logic            clk,
    input  logic            rst,
    input  logic            cen,
    input  mmr_pkg::presc_t presc,
    output logic            clk_en
);
    import mmr_pkg::*;

    presc_t     presc_q;   // Setting the count runs under
    logic [2:0] cnt;
    logic [2:0] last;

    always_comb begin
        case (presc_q)
            PRESC_3: last = 3'd2;
            PRESC_2: last = 3'd1;
            default: last = 3'd5;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            presc_q <= PRESC_6;
            cnt     <= '0;
            clk_en  <= 1'b0;
        end else if (presc != presc_q) begin
            // New ratio, count from scratch
            presc_q <= presc;
            cnt     <= '0;
            clk_en  <= 1'b0;
        end else if (cen) begin
            if (cnt == last) begin
                cnt    <= '0;
                clk_en <= 1'b1;
            end else begin
                cnt    <= cnt + 3'd1;
                clk_en <= 1'b0;
            end
        end else begin
            clk_en <= 1'b0;
        end
    end

endmodule

//--- hw/fm_mmr_top.sv
module fm_mmr_top #(
    parameter int FIFO_DEPTH = mmr_pkg::DEFAULT_FIFO_DEPTH
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      cen,
    input  logic [mmr_pkg::REG_W-1:0] din,
    input  logic                      write,
    input  logic [1:0]                addr,
    output logic                      busy,
    output logic                      clk_en,
    output logic [9:0]                value_a,
    output logic [7:0]                value_b,
    output logic                      load_a,
    output logic                      load_b,
    output logic                      enable_irq_a,
    output logic                      enable_irq_b,
    output logic                      clr_flag_a,
    output logic                      clr_flag_b,
    output logic                      fast_timers,
    output logic                      eg_stop,
    output logic                      pg_stop,
    output logic                      lfo_en,
    output logic [2:0]                lfo_freq,
    output logic                      csm,
    output logic                      effect,
    output logic [8:0]                pcm,
    output logic                      pcm_en,
    output logic                      pcm_wr,
    output logic                      upd_valid,
    output mmr_pkg::upd_kind_t        upd_kind,
    output logic [mmr_pkg::CH_W-1:0]  upd_ch,
    output logic [mmr_pkg::OP_W-1:0]  upd_op,
    output logic [mmr_pkg::REG_W-1:0] upd_data
);
    import mmr_pkg::*;

    logic             push;
    logic [REG_W-1:0] push_reg;
    logic [REG_W-1:0] push_data;
    logic             push_bank;
    logic             not_empty;
    logic [REG_W-1:0] head_reg;
    logic [REG_W-1:0] head_data;
    logic             head_bank;
    logic             pop;       // Also the credit return
    presc_t           presc;

    bus_decoder #(.FIFO_DEPTH(FIFO_DEPTH)) i_bus_decoder (
        .clk(clk), .rst(rst), .din(din), .write(write), .addr(addr),
        .credit_return(pop), .push(push), .push_reg(push_reg),
        .push_data(push_data), .push_bank(push_bank), .presc(presc), .busy(busy)
    );

    write_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) i_write_fifo (
        .clk(clk), .rst(rst), .push(push), .push_reg(push_reg),
        .push_data(push_data), .push_bank(push_bank), .pop(pop),
        .not_empty(not_empty), .head_reg(head_reg), .head_data(head_data),
        .head_bank(head_bank)
    );

    reg_bank i_reg_bank (
        .clk(clk), .rst(rst), .clk_en(clk_en), .not_empty(not_empty),
        .head_reg(head_reg), .head_data(head_data), .head_bank(head_bank), .pop(pop),
        .value_a(value_a), .value_b(value_b), .load_a(load_a), .load_b(load_b),
        .enable_irq_a(enable_irq_a), .enable_irq_b(enable_irq_b),
        .clr_flag_a(clr_flag_a), .clr_flag_b(clr_flag_b), .fast_timers(fast_timers),
        .eg_stop(eg_stop), .pg_stop(pg_stop), .lfo_en(lfo_en), .lfo_freq(lfo_freq),
        .csm(csm), .effect(effect), .pcm(pcm), .pcm_en(pcm_en), .pcm_wr(pcm_wr),
        .upd_valid(upd_valid), .upd_kind(upd_kind), .upd_ch(upd_ch),
        .upd_op(upd_op), .upd_data(upd_data)
    );

    cen_divider i_cen_divider (
        .clk(clk), .rst(rst), .cen(cen), .presc(presc), .clk_en(clk_en)
    );

endmodule

//--- dv/fm_mmr_asserts.sv
module fm_mmr_asserts (
    input logic clk,
    input logic rst,
    input logic push,
    input logic busy,
    input logic pop,
    input logic upd_valid
);
    timeunit 1ns;
    timeprecision 1ps;

    // A push spends a credit held in the cycle of its write
    a_push_credit: assert property (@(posedge clk) disable iff (rst) push |-> !$past(busy))
        else $error("push issued with no credit left");

    a_upd_single: assert property (@(posedge clk) disable iff (rst) upd_valid |=> !upd_valid)
        else $error("upd_valid high for two cycles");

    // Credits only come back through a pop
    a_busy_fall: assert property (@(posedge clk) disable iff (rst) $fell(busy) |-> $past(pop))
        else $error("busy fell without a pop");

endmodule

//--- dv/tb_fm_mmr.sv
module tb_fm_mmr;
    timeunit 1ns;
    timeprecision 1ps;
    import mmr_pkg::*;

    localparam int N_GLOBAL   = 16;
    localparam int N_UPD      = 24;                 // Groups of four
    localparam int N_WRITES   = 2 * N_GLOBAL + 8 + 2 * N_UPD + 7 + 3;
    localparam int CLK_NS     = 10;
    localparam int TIMEOUT_NS = N_WRITES * 200 * 6 * CLK_NS;

    logic clk, rst, cen, write;
    logic [REG_W-1:0] din;
    logic [1:0] addr;
    logic busy, clk_en, load_a, load_b, enable_irq_a, enable_irq_b, clr_flag_a, clr_flag_b;
    logic fast_timers, eg_stop, pg_stop, lfo_en, csm, effect, pcm_en, pcm_wr, upd_valid;
    logic [9:0] value_a;
    logic [7:0] value_b;
    logic [2:0] lfo_freq;
    logic [8:0] pcm;
    upd_kind_t upd_kind;
    logic [CH_W-1:0] upd_ch;
    logic [OP_W-1:0] upd_op;
    logic [REG_W-1:0] upd_data;

    // Expected register state
    logic [9:0] m_value_a = '0;
    logic [7:0] m_value_b = '0;
    logic [2:0] m_lfo_freq = '0;
    logic [8:0] m_pcm = '0;
    logic m_load_a = 0, m_load_b = 0, m_irq_a = 0, m_irq_b = 0, m_csm = 0, m_effect = 0;
    logic m_fast = 0, m_eg_stop = 0, m_pg_stop = 0, m_lfo_en = 0, m_pcm_en = 0;

    logic [16:0] pending[$];                        // {bank, reg, data} per accepted write
    int err_value = 0;
    int err_other = 0;
    int events = 0;
    int pulses = 0;

    fm_mmr_top #(.FIFO_DEPTH(4)) i_fm_mmr_top (.*);

    bind fm_mmr_top fm_mmr_asserts i_fm_mmr_asserts (
        .clk(clk), .rst(rst), .push(push), .busy(busy), .pop(pop), .upd_valid(upd_valid)
    );

    function automatic upd_kind_t ref_kind(input logic bank, input logic [7:0] r);
        if (!bank && r == REG_KON) return UPD_KEYON;
        if (r[1:0] == 2'b11) return UPD_NONE;       // Only three channels per bank
        if (r >= 8'hA0 && r <= 8'hA2) return UPD_FNUMLO;
        if (r >= 8'hB0 && r <= 8'hB2) return UPD_ALG;
        if (r >= 8'hB4 && r <= 8'hB6) return UPD_PMS;
        case (r[7:4])
            4'h3: return UPD_DT1;
            4'h4: return UPD_TL;
            4'h5: return UPD_KS_AR;
            4'h6: return UPD_AMEN_DR;
            4'h7: return UPD_SR;
            4'h8: return UPD_SL_RR;
            4'h9: return UPD_SSGEG;
            default: return UPD_NONE;
        endcase
    endfunction

    task automatic model_apply(input logic bank, input logic [7:0] r, input logic [7:0] d);
        if (!bank) begin
            case (r)
                REG_TESTYM: begin
                    m_eg_stop = d[5];
                    m_pg_stop = d[3];
                    m_fast    = d[2];
                end
                REG_LFO: begin
                    m_lfo_en   = d[3];
                    m_lfo_freq = d[2:0];
                end
                REG_CLKA1: m_value_a[9:2] = d;
                REG_CLKA2: m_value_a[1:0] = d[1:0];
                REG_CLKB:  m_value_b = d;
                REG_TIMER: begin
                    m_effect = d[7] | d[6];
                    m_csm    = d[7] & ~d[6];
                    m_irq_b  = d[3];
                    m_irq_a  = d[2];
                    m_load_b = d[1];
                    m_load_a = d[0];
                end
                default: ;
            endcase
        end
        case (r)
            REG_PCM:     m_pcm = {~d[7], d[6:0], 1'b1};
            REG_PCM_EN:  m_pcm_en = d[7];
            REG_DACTEST: m_pcm[0] = d[3];
            default: ;
        endcase
    endtask

    function automatic logic [7:0] pick_global(input int i);
        case (i)
            0: return REG_TESTYM;
            1: return REG_LFO;
            2: return REG_CLKA1;
            3: return REG_CLKA2;
            4: return REG_CLKB;
            default: return REG_TIMER;
        endcase
    endfunction

    function automatic logic [7:0] pick_chan_reg();
        if ($urandom % 8 == 0) return REG_KON;
        return 8'h30 + 8'($urandom % 135);          // 30h up to B6h
    endfunction

    task automatic value_error(input string msg);
        err_value++;
        $display("[ERROR] %0t %s", $time, msg);
    endtask

    task automatic print_counts();
        $display("Errors: %0d value, %0d other", err_value, err_other);
    endtask

    task automatic check_registers();
        assert ({value_a, value_b} == {m_value_a, m_value_b}) else
            value_error($sformatf("timer values %h/%h, expected %h/%h",
                                  value_a, value_b, m_value_a, m_value_b));
        assert ({load_a, load_b, enable_irq_a, enable_irq_b, csm, effect} ==
                {m_load_a, m_load_b, m_irq_a, m_irq_b, m_csm, m_effect}) else
            value_error("timer control bits differ from expected");
        assert ({fast_timers, eg_stop, pg_stop, lfo_en, lfo_freq} ==
                {m_fast, m_eg_stop, m_pg_stop, m_lfo_en, m_lfo_freq}) else
            value_error("test or LFO bits differ from expected");
        assert ({pcm, pcm_en} == {m_pcm, m_pcm_en}) else
            value_error($sformatf("pcm %h en %b, expected %h en %b", pcm, pcm_en, m_pcm, m_pcm_en));
    endtask

    // One host bus cycle, called 1 ns after a rising edge
    task automatic host_cycle(input logic [1:0] a, input logic [7:0] d);
        write = 1'b1;
        addr  = a;
        din   = d;
        @(posedge clk);
        #1;
        write = 1'b0;
    endtask

    task automatic select_reg(input logic bank, input logic [7:0] r);
        host_cycle({bank, 1'b0}, r);
    endtask

    task automatic data_write(input logic bank, input logic [7:0] r, input logic [7:0] d);
        select_reg(bank, r);
        pending.push_back({bank, r, d});
        host_cycle({bank, 1'b1}, d);
    endtask

    task automatic wait_drain();
        while (pending.size() != 0) @(posedge clk);
        @(posedge clk);
        #1;
    endtask

    task automatic wait_pulse();
        do @(negedge clk); while (!clk_en);
    endtask

    task automatic check_period(input logic [7:0] r, input int expected);
        int p;
        select_reg(1'b0, r);
        wait_pulse();                               // May still be the old ratio
        wait_pulse();
        p = 0;
        do begin
            @(negedge clk);
            p++;
        end while (!clk_en);
        assert (p == expected) else
            value_error($sformatf("clk_en period %0d after select %h, expected %0d", p, r, expected));
        @(posedge clk);
        #1;
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    initial begin
        forever begin
            @(negedge clk);
            if (clk_en) pulses++;
        end
    end

    // Compare each update event with the oldest accepted write
    initial begin
        logic b;
        logic [7:0] r;
        logic [7:0] d;
        upd_kind_t exp_kind;
        forever begin
            @(negedge clk);
            if (upd_valid) begin
                events++;
                if (pending.size() == 0) begin
                    err_other++;
                    $display("An update event came out with no accepted write pending");
                end else begin
                    {b, r, d} = pending.pop_front();
                    model_apply(b, r, d);
                    exp_kind = ref_kind(b, r);
                    assert (upd_kind == exp_kind) else
                        value_error($sformatf("bank %0d reg %h kind %s, expected %s",
                                              b, r, upd_kind.name(), exp_kind.name()));
                    assert ({upd_ch, upd_op, upd_data} == {b, r[1:0], r[3:2], d}) else
                        value_error($sformatf("bank %0d reg %h: ch %0d op %0d data %h",
                                              b, r, upd_ch, upd_op, upd_data));
                    assert (pcm_wr == (r == REG_PCM)) else
                        value_error($sformatf("pcm_wr %b after reg %h", pcm_wr, r));
                    assert ({clr_flag_b, clr_flag_a} ==
                            ((!b && r == REG_TIMER) ? d[5:4] : 2'b00)) else
                        value_error($sformatf("clear flags %b%b after reg %h", clr_flag_b,
                                              clr_flag_a, r));
                    check_registers();
                end
            end
        end
    end

    initial begin
        #(TIMEOUT_NS);
        err_other++;
        $display("Timeout: the run did not finish in the allowed time");
        print_counts();
        $display("tests failed");
        $finish;
    end

    initial begin
        logic [7:0] r;
        logic [7:0] d;
        int base_pulses;
        int base_events;
        void'($urandom(14));
        rst   = 1'b1;
        cen   = 1'b1;
        write = 1'b0;
        addr  = 2'b00;
        din   = '0;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;

        assert ({busy, upd_valid, pcm_wr, clr_flag_a, clr_flag_b} == 5'b0) else
            value_error("status outputs not low after reset");
        check_registers();

        for (int i = 0; i < N_GLOBAL; i++) begin
            data_write(1'b0, pick_global(int'($urandom % 6)), 8'($urandom));
            wait_drain();
        end

        data_write(1'b0, REG_PCM, 8'($urandom));
        wait_drain();
        data_write(1'b1, REG_PCM, 8'($urandom));    // DAC answers in bank 1 too
        wait_drain();
        data_write(1'b0, REG_PCM_EN, 8'h80);
        wait_drain();
        data_write(1'b1, REG_DACTEST, 8'h00);
        wait_drain();

        for (int g = 0; g < N_UPD / 4; g++) begin
            for (int k = 0; k < 4; k++) begin
                data_write(1'($urandom), pick_chan_reg(), 8'($urandom));
            end
            wait_drain();
        end

        // Credits run out with the consumer stalled
        cen = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        base_pulses = pulses;
        base_events = events;
        r = 8'h40 + 8'($urandom % 16);
        select_reg(1'b0, r);
        for (int i = 0; i < 6; i++) begin
            d = 8'($urandom);
            assert (busy == (i >= 4)) else
                value_error($sformatf("busy %b before data write %0d", busy, i));
            if (i < 4) pending.push_back({1'b0, r, d});
            host_cycle(2'b01, d);
        end
        repeat (10) @(posedge clk);
        #1;
        assert (busy) else value_error("busy low with all credits spent");
        assert (pulses == base_pulses) else value_error("clk_en pulsed with cen low");
        assert (events == base_events) else value_error("update event with cen low");
        cen = 1'b1;
        wait_drain();
        repeat (40) @(posedge clk);
        #1;
        assert (events == base_events + 4) else
            value_error($sformatf("%0d update events after stall, expected 4",
                                  events - base_events));
        assert (!busy) else value_error("busy still high after the FIFO drained");

        check_period(REG_CLK_N6, 6);
        check_period(REG_CLK_N3, 3);
        check_period(REG_CLK_N2, 2);

        print_counts();
        if (err_value + err_other == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

//--- build.f
hw/mmr_pkg.sv
hw/bus_decoder.sv
hw/write_fifo.sv
hw/reg_bank.sv
hw/cen_divider.sv
hw/fm_mmr_top.sv
dv/fm_mmr_asserts.sv
dv/tb_fm_mmr.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_fm_mmr -f build.f -Mdir obj_dir -o sim_tb_fm_mmr

./obj_dir/sim_tb_fm_mmr | tee sim.log

if grep -qx "all tests passed" sim.log; then
    echo "Simulation result: PASS"
    exit 0
else
    echo "Simulation result: FAIL"
    exit 1
fi
